// File: include/cpu_settings.svh
// --------------------
// core size settings
// the ISA assumes a 16-bit data word,
// so CPU_DW is not free to change
// CPU_NREGS must be a power of two
// the reset pc is a full bus address
// --------------------
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// first fetch address after reset
`define CPU_PC_RSTVAL 24'h000000

// bus and register bank sizes
`define CPU_AW 24
`define CPU_DW 16
`define CPU_NREGS 8

`endif

// File: design/cpu_isa_pkg.sv
// --------------------
// instruction set of the core
// word layout: [15:12] opcode, [10:8] rd, [6:4] rs, [7:0] rel (JRNZ only)
// LD  rd,(rs) reads rd from mem[rs]
// ST / STB (rd),rs write rs to mem[rd]
// opcodes not listed act as HALT
// --------------------
package cpu_isa_pkg;

    localparam int unsigned IR_OP_LSB  = 12;
    localparam int unsigned IR_DST_LSB = 8;
    localparam int unsigned IR_SRC_LSB = 4;

    typedef logic [15:0] cpu_insn_t;
    typedef logic [7:0]  cpu_rel_t;
    typedef logic [2:0]  cpu_rfld_t;

    typedef enum logic [3:0] {
        OP_NOP = 4'h0, OP_LDI, OP_ADD, OP_SUB, OP_AND,
        OP_XOR, OP_LD, OP_ST, OP_STB, OP_JRNZ,
        OP_HALT = 4'hF
    } cpu_opcode_t;

    typedef enum logic [1:0] {ADD, SUB, AND, XOR} cpu_aluop_t;

    function automatic cpu_opcode_t ir_opcode(cpu_insn_t ir);
        return cpu_opcode_t'(ir[IR_OP_LSB +: 4]);
    endfunction

    function automatic cpu_rfld_t ir_dst(cpu_insn_t ir);
        return ir[IR_DST_LSB +: 3];
    endfunction

    function automatic cpu_rfld_t ir_src(cpu_insn_t ir);
        return ir[IR_SRC_LSB +: 3];
    endfunction

    // register form, also used for NOP, LDI and the memory ops
    function automatic cpu_insn_t cpu_enc(cpu_opcode_t op, cpu_rfld_t dst, cpu_rfld_t src);
        return {op, 1'b0, dst, 1'b0, src, 4'h0};
    endfunction

    function automatic cpu_insn_t cpu_enc_jr(cpu_rel_t rel);
        return {OP_JRNZ, 4'h0, rel};
    endfunction

endpackage

// File: design/cpu_core_pkg.sv
// --------------------
// core datapath types
// widths follow cpu_settings.svh
// --------------------
`include "cpu_settings.svh"

package cpu_core_pkg;

    typedef logic [`CPU_DW-1:0] cpu_word_t;
    typedef logic [`CPU_AW-1:0] cpu_addr_t;
    typedef logic [$clog2(`CPU_NREGS)-1:0] cpu_ridx_t;

    // sequencer states
    typedef enum logic [2:0] {FETCH, DECODE, IMM, MEM, HALT} cpu_state_t;

    // register write-back source
    typedef enum logic [1:0] {WB_ALU, WB_IMM, WB_MEM} cpu_wbsel_t;

    // bus address source
    typedef enum logic {BUS_PC, BUS_REG} cpu_bussel_t;

endpackage

// File: design/cpu_ctrl.sv
// --------------------
// instruction sequencer
// one instruction at a time, 2 or 3 enabled cycles each
// decode reads ir straight from the bus in DECODE
// HALT is left only through reset
// --------------------
module cpu_ctrl
    import cpu_core_pkg::*;
    import cpu_isa_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  logic        cen,
    input  cpu_insn_t   ir,
    input  logic        zero,

    output logic        pc_inc,
    output logic        pc_rel_we,
    output logic        reg_we,
    output cpu_ridx_t   reg_dst,
    output cpu_ridx_t   reg_src,
    output cpu_wbsel_t  wdata_sel,
    output cpu_aluop_t  alu_op,
    output logic        flag_we,
    output cpu_bussel_t bus_sel,
    output logic        mem_wr,
    output logic        mem_byte,
    output logic        latch_en,
    output logic        halted
);

cpu_state_t  state, state_nx;
cpu_opcode_t opcode;

assign opcode = ir_opcode(ir);
assign halted = state == HALT;

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        state <= FETCH;
    end else if (cen) begin
        state <= state_nx;
    end
end

always_comb begin
    state_nx  = state;
    pc_inc    = 1'b0;
    pc_rel_we = 1'b0;
    reg_we    = 1'b0;
    reg_dst   = ir_dst(ir);
    reg_src   = ir_src(ir);
    wdata_sel = WB_ALU;
    alu_op    = ADD;
    flag_we   = 1'b0;
    bus_sel   = BUS_PC;
    mem_wr    = 1'b0;
    mem_byte  = 1'b0;
    latch_en  = 1'b0;
    case (state)
        FETCH: begin
            // pc moves past the instruction word while it is read
            pc_inc   = 1'b1;
            state_nx = DECODE;
        end
        DECODE: begin
            latch_en = 1'b1;
            state_nx = FETCH;
            case (opcode)
                OP_NOP: begin
                end
                OP_LDI: begin
                    // bus already shows the immediate word
                    pc_inc   = 1'b1;
                    state_nx = IMM;
                end
                OP_ADD, OP_SUB, OP_AND, OP_XOR: begin
                    reg_we  = 1'b1;
                    flag_we = 1'b1;
                    case (opcode)
                        OP_SUB:  alu_op = SUB;
                        OP_AND:  alu_op = AND;
                        OP_XOR:  alu_op = XOR;
                        default: alu_op = ADD;
                    endcase
                end
                OP_LD: begin
                    // address comes out of the dst read port
                    reg_dst  = ir_src(ir);
                    bus_sel  = BUS_REG;
                    state_nx = MEM;
                end
                OP_ST, OP_STB: begin
                    state_nx = MEM;
                end
                OP_JRNZ: begin
                    pc_rel_we = !zero;
                end
                default: begin
                    state_nx = HALT;
                end
            endcase
        end
        IMM: begin
            reg_we    = 1'b1;
            wdata_sel = WB_IMM;
            state_nx  = FETCH;
        end
        MEM: begin
            state_nx = FETCH;
            if (opcode == OP_LD) begin
                reg_we    = 1'b1;
                wdata_sel = WB_MEM;
            end else begin
                bus_sel  = BUS_REG;
                mem_wr   = 1'b1;
                mem_byte = opcode == OP_STB;
            end
        end
        default: begin
            // halted, nothing moves
        end
    endcase
end

endmodule

// File: design/cpu_regs.sv
// --------------------
// register bank, CPU_NREGS words
// reads are combinational, one write per enabled cycle
// write-back mux selects ALU or bus data
// --------------------
`include "cpu_settings.svh"

module cpu_regs
    import cpu_core_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       cen,

    input  logic       reg_we,
    input  cpu_ridx_t  reg_dst,
    input  cpu_ridx_t  reg_src,
    input  cpu_wbsel_t wdata_sel,
    input  cpu_word_t  alu_res,
    input  cpu_word_t  rdata,

    output cpu_word_t  dst_out,
    output cpu_word_t  src_out,

    // host dump port
    input  cpu_ridx_t  dmp_addr,
    output cpu_word_t  dmp_dout
);

cpu_word_t regs [`CPU_NREGS];
cpu_word_t wdata;

// immediate and load data both arrive on the bus
always_comb begin
    case (wdata_sel)
        WB_IMM, WB_MEM: wdata = rdata;
        default:        wdata = alu_res;
    endcase
end

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        for (int i = 0; i < `CPU_NREGS; i++) begin
            regs[i] <= '0;
        end
    end else if (cen && reg_we) begin
        regs[reg_dst] <= wdata;
    end
end

assign dst_out  = regs[reg_dst];
assign src_out  = regs[reg_src];
assign dmp_dout = regs[dmp_addr];

endmodule

// File: design/cpu_alu.sv
// --------------------
// ALU, results wrap modulo 2^16
// carry is the carry out of ADD or the borrow of SUB
// AND and XOR clear the carry
// flags update only on flag_we
// --------------------
module cpu_alu
    import cpu_core_pkg::*;
    import cpu_isa_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       cen,

    input  cpu_aluop_t alu_op,
    input  cpu_word_t  op_a,
    input  cpu_word_t  op_b,
    input  logic       flag_we,

    output cpu_word_t  result,
    output logic       zero
);

localparam int DW = $bits(cpu_word_t);

logic [DW:0] wide;
// {carry, zero}
logic [1:0]  flags;

always_comb begin
    case (alu_op)
        ADD: wide = {1'b0, op_a} + {1'b0, op_b};
        // top bit set means a borrow
        SUB: wide = {1'b0, op_a} - {1'b0, op_b};
        AND: wide = {1'b0, op_a & op_b};
        default: wide = {1'b0, op_a ^ op_b};
    endcase
end

assign result = wide[DW-1:0];

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        flags <= 2'b00;
    end else if (cen && flag_we) begin
        flags <= {wide[DW], result == '0};
    end
end

assign zero = flags[0];

endmodule

// File: design/cpu_pc.sv
// --------------------
// program counter
// steps by 2 per word, as addr carries the pc unchanged
// branch target is pc + 2*sext(rel), with pc already past the opcode
// --------------------
`include "cpu_settings.svh"

module cpu_pc
    import cpu_core_pkg::*;
    import cpu_isa_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      cen,

    input  logic      pc_inc,
    input  logic      pc_rel_we,
    input  cpu_rel_t  rel,

    output cpu_addr_t pc
);

cpu_addr_t rel_step;

// sign extend and scale by two
assign rel_step = {{(`CPU_AW-9){rel[7]}}, rel, 1'b0};

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        pc <= `CPU_PC_RSTVAL;
    end else if (cen) begin
        if (pc_rel_we) begin
            pc <= pc + rel_step;
        end else if (pc_inc) begin
            pc <= pc + cpu_addr_t'(2);
        end
    end
end

endmodule

// File: design/cpu_busctl.sv
// --------------------
// memory bus controller
// register addresses are zero extended to the bus width
// STB uses address bit 0 for the lane, 0 is the low byte
// din is valid one enabled cycle after addr
// --------------------
module cpu_busctl
    import cpu_core_pkg::*;
    import cpu_isa_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  logic        cen,

    input  cpu_bussel_t bus_sel,
    input  cpu_addr_t   pc,
    input  cpu_word_t   reg_addr,
    input  cpu_word_t   wr_data,
    input  logic        mem_wr,
    input  logic        mem_byte,
    input  logic        latch_en,
    input  cpu_word_t   din,

    output cpu_addr_t   addr,
    output cpu_word_t   dout,
    output logic [1:0]  we,
    output cpu_insn_t   ir,
    output cpu_word_t   rdata
);

cpu_insn_t ir_q;

assign addr = bus_sel == BUS_REG ? cpu_addr_t'(reg_addr) : pc;

always_comb begin
    we   = 2'b00;
    dout = wr_data;
    if (mem_wr) begin
        if (mem_byte) begin
            we   = reg_addr[0] ? 2'b10 : 2'b01;
            dout = reg_addr[0] ? {wr_data[7:0], 8'h00} : {8'h00, wr_data[7:0]};
        end else begin
            we = 2'b11;
        end
    end
end

// opcode word kept for the IMM and MEM cycles
always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        ir_q <= '0;
    end else if (cen && latch_en) begin
        ir_q <= din;
    end
end

// decode sees the word as it arrives
assign ir    = latch_en ? din : ir_q;
assign rdata = din;

endmodule

// File: design/cpu_top.sv
// --------------------
// 16-bit core top level
// addr is driven unchanged from pc or a register
// din must follow addr by one enabled cycle
// cen low freezes the whole core
// --------------------
module cpu_top
    import cpu_core_pkg::*;
    import cpu_isa_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       cen,

    output cpu_addr_t  addr,
    input  cpu_word_t  din,
    output cpu_word_t  dout,
    output logic [1:0] we,

    // register dump
    input  cpu_ridx_t  dmp_addr,
    output cpu_word_t  dmp_dout,

    output logic       halted
);

// sequencer controls
logic        pc_inc, pc_rel_we;
logic        reg_we, flag_we;
logic        mem_wr, mem_byte, latch_en;
cpu_ridx_t   reg_dst, reg_src;
cpu_wbsel_t  wdata_sel;
cpu_aluop_t  alu_op;
cpu_bussel_t bus_sel;

// datapath
cpu_insn_t   ir;
cpu_addr_t   pc;
cpu_word_t   dst_out, src_out, alu_res, rdata;
logic        zero;

cpu_ctrl u_ctrl (
    .clk        ( clk        ),
    .arst_n     ( arst_n     ),
    .cen        ( cen        ),
    .ir         ( ir         ),
    .zero       ( zero       ),
    .pc_inc     ( pc_inc     ),
    .pc_rel_we  ( pc_rel_we  ),
    .reg_we     ( reg_we     ),
    .reg_dst    ( reg_dst    ),
    .reg_src    ( reg_src    ),
    .wdata_sel  ( wdata_sel  ),
    .alu_op     ( alu_op     ),
    .flag_we    ( flag_we    ),
    .bus_sel    ( bus_sel    ),
    .mem_wr     ( mem_wr     ),
    .mem_byte   ( mem_byte   ),
    .latch_en   ( latch_en   ),
    .halted     ( halted     )
);

cpu_regs u_regs (
    .clk        ( clk        ),
    .arst_n     ( arst_n     ),
    .cen        ( cen        ),
    .reg_we     ( reg_we     ),
    .reg_dst    ( reg_dst    ),
    .reg_src    ( reg_src    ),
    .wdata_sel  ( wdata_sel  ),
    .alu_res    ( alu_res    ),
    .rdata      ( rdata      ),
    .dst_out    ( dst_out    ),
    .src_out    ( src_out    ),
    .dmp_addr   ( dmp_addr   ),
    .dmp_dout   ( dmp_dout   )
);

cpu_alu u_alu (
    .clk        ( clk        ),
    .arst_n     ( arst_n     ),
    .cen        ( cen        ),
    .alu_op     ( alu_op     ),
    .op_a       ( dst_out    ),
    .op_b       ( src_out    ),
    .flag_we    ( flag_we    ),
    .result     ( alu_res    ),
    .zero       ( zero       )
);

cpu_pc u_pc (
    .clk        ( clk        ),
    .arst_n     ( arst_n     ),
    .cen        ( cen        ),
    .pc_inc     ( pc_inc     ),
    .pc_rel_we  ( pc_rel_we  ),
    .rel        ( ir[7:0]    ),
    .pc         ( pc         )
);

// stores address through rd and take data from rs
cpu_busctl u_busctl (
    .clk        ( clk        ),
    .arst_n     ( arst_n     ),
    .cen        ( cen        ),
    .bus_sel    ( bus_sel    ),
    .pc         ( pc         ),
    .reg_addr   ( dst_out    ),
    .wr_data    ( src_out    ),
    .mem_wr     ( mem_wr     ),
    .mem_byte   ( mem_byte   ),
    .latch_en   ( latch_en   ),
    .din        ( din        ),
    .addr       ( addr       ),
    .dout       ( dout       ),
    .we         ( we         ),
    .ir         ( ir         ),
    .rdata      ( rdata      )
);

endmodule

// File: testbench/cpu_assert.sv
// --------------------
// bus and control checks, bound into cpu_top
// sampled on every rising clock edge
// cen low must freeze the bus outputs
// --------------------
module cpu_assert
    import cpu_core_pkg::*;
(
    input logic       clk,
    input logic       arst_n,
    input logic       cen,
    input cpu_addr_t  addr,
    input cpu_word_t  dout,
    input logic [1:0] we,
    input logic       halted
);

// no write strobe while in reset
a_we_in_reset: assert property (@(posedge clk) !arst_n |-> we == 2'b00)
    else $error("write enable active during reset");

// a halted core never writes
a_no_write_halted: assert property (@(posedge clk) disable iff (!arst_n)
    halted |-> we == 2'b00)
    else $error("write enable active after halt");

a_bus_hold: assert property (@(posedge clk) disable iff (!arst_n)
    !cen |=> $stable(addr) && $stable(dout) && $stable(we))
    else $error("bus outputs changed while cen was low");

// halt is sticky until reset
a_halt_sticky: assert property (@(posedge clk) disable iff (!arst_n)
    halted |=> halted)
    else $error("halted dropped without reset");

endmodule

bind cpu_top cpu_assert u_assert (.*);

// File: testbench/tb_cpu.sv
// --------------------
// testbench for cpu_top
// memory model is 64K words, indexed by addr[16:1]
// din follows addr by one enabled edge
// program and expected writes built at time zero
// --------------------
`include "cpu_settings.svh"

module tb_cpu
    import cpu_isa_pkg::*;
;

logic        clk;
logic        arst_n;
logic        cen;
logic [23:0] addr;
logic [15:0] din;
logic [15:0] dout;
logic [1:0]  we;
logic [2:0]  dmp_addr;
logic [15:0] dmp_dout;
logic        halted;

logic [15:0] mem [65536];
logic [15:0] model [8];
logic [23:0] exp_addr [$];
logic [15:0] exp_data [$];
logic [1:0]  exp_we [$];
int          pc_w;
int          errors;
bit          first_seen;

cpu_top dut (.*);

initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
end

task automatic check_value(string name, logic [23:0] exp, logic [23:0] act);
    if (exp !== act) begin
        $display("** Error %s: expected %h, actual %h", name, exp, act);
        errors++;
    end
endtask

task automatic put_word(logic [15:0] w);
    mem[pc_w] = w;
    pc_w++;
endtask

task automatic expect_write(logic [15:0] a, logic [15:0] d, logic [1:0] w);
    exp_addr.push_back({8'h00, a});
    exp_data.push_back(d);
    exp_we.push_back(w);
endtask

function automatic logic [15:0] apply_alu(cpu_opcode_t op, logic [15:0] a, logic [15:0] b);
    case (op)
        OP_ADD:  return a + b;
        OP_SUB:  return a - b;
        OP_AND:  return a & b;
        default: return a ^ b;
    endcase
endfunction

task automatic ldi_insn(cpu_rfld_t rd, logic [15:0] val);
    put_word(cpu_enc(OP_LDI, rd, 0));
    put_word(val);
    model[rd] = val;
endtask

task automatic alu_insn(cpu_opcode_t op, cpu_rfld_t rd, cpu_rfld_t rs);
    put_word(cpu_enc(op, rd, rs));
    model[rd] = apply_alu(op, model[rd], model[rs]);
endtask

task automatic ld_insn(cpu_rfld_t rd, cpu_rfld_t rs);
    put_word(cpu_enc(OP_LD, rd, rs));
    model[rd] = mem[model[rs][15:1]];
endtask

// store rs at the address held in rd
task automatic store_insn(cpu_rfld_t rd, cpu_rfld_t rs, bit is_byte);
    logic [15:0] a;
    logic [15:0] v;
    a = model[rd];
    v = model[rs];
    put_word(cpu_enc(is_byte ? OP_STB : OP_ST, rd, rs));
    if (!is_byte) begin
        expect_write(a, v, 2'b11);
    end else if (a[0]) begin
        expect_write(a, {v[7:0], 8'h00}, 2'b10);
    end else begin
        expect_write(a, {8'h00, v[7:0]}, 2'b01);
    end
endtask

task automatic build_program();
    cpu_opcode_t ops [4];
    ops = '{OP_ADD, OP_SUB, OP_AND, OP_XOR};
    for (int i = 0; i < 65536; i++) begin
        mem[i] = 16'(i * 16'h9e37) ^ 16'h5a5a;
    end
    mem[16'h00c0] = 16'hbeef;
    mem[16'h0100] = 16'haaaa;
    pc_w = 0;
    // arithmetic, one word store per op
    ldi_insn(2, 16'hf0f5);
    ldi_insn(7, 16'h0100);
    ldi_insn(6, 16'h0002);
    put_word(cpu_enc(OP_NOP, 0, 0));
    foreach (ops[i]) begin
        ldi_insn(3, 16'h1234);
        alu_insn(ops[i], 3, 2);
        store_insn(7, 3, 1'b0);
        alu_insn(OP_ADD, 7, 6);
    end
    // load and copy back
    ldi_insn(4, 16'h0180);
    ld_insn(5, 4);
    store_insn(7, 5, 1'b0);
    alu_insn(OP_ADD, 7, 6);
    // countdown loop, three words per pass
    ldi_insn(0, 16'd5);
    ldi_insn(1, 16'd1);
    put_word(cpu_enc(OP_SUB, 0, 1));
    put_word(cpu_enc(OP_ST, 7, 0));
    put_word(cpu_enc_jr(8'hfd));
    for (int k = 4; k >= 0; k--) begin
        expect_write(model[7], 16'(k), 2'b11);
    end
    model[0] = 16'h0000;
    // byte lanes of one preset word
    ldi_insn(3, 16'h0201);
    ldi_insn(4, 16'h0200);
    ldi_insn(5, 16'h1234);
    ldi_insn(2, 16'h0055);
    store_insn(3, 5, 1'b1);
    store_insn(4, 2, 1'b1);
    put_word(16'hf000);
endtask

// memory model and write scoreboard
always @(posedge clk) begin
    logic [1:0]  exp_lanes;
    logic [15:0] lane_mask;
    if (arst_n && cen) begin
        if (!first_seen) begin
            first_seen = 1'b1;
            check_value("first fetch addr", `CPU_PC_RSTVAL, addr);
            check_value("first fetch we", 24'h0, {22'h0, we});
        end
        if (we != 2'b00) begin
            if (exp_addr.size() == 0) begin
                $display("unexpected write of %h to %h", dout, addr);
                errors++;
            end else begin
                // only the enabled byte lanes carry data
                exp_lanes = exp_we.pop_front();
                lane_mask = {{8{exp_lanes[1]}}, {8{exp_lanes[0]}}};
                check_value("write addr", exp_addr.pop_front(), addr);
                check_value("write data", {8'h00, exp_data.pop_front() & lane_mask},
                            {8'h00, dout & lane_mask});
                check_value("write enables", {22'h0, exp_lanes}, {22'h0, we});
            end
            if (we[0]) mem[addr[16:1]][7:0] <= dout[7:0];
            if (we[1]) mem[addr[16:1]][15:8] <= dout[15:8];
        end
        din <= mem[addr[16:1]];
    end
end

// random clock enable, about 75 percent high
initial begin
    cen = 1'b0;
    void'($urandom(32'h333d2836));
    forever begin
        @(posedge clk);
        cen <= ($urandom % 4) != 0;
    end
end

initial begin
    int cycles;
    arst_n = 1'b0;
    din = '0;
    dmp_addr = '0;
    errors = 0;
    first_seen = 1'b0;
    build_program();
    repeat (2) @(posedge clk);
    arst_n <= 1'b1;
    cycles = 0;
    while (!halted && cycles < 5000) begin
        @(posedge clk);
        cycles++;
    end
    if (!halted) begin
        $display("timeout waiting for halted");
        $display("errors: %0d", errors + 1);
        $display("TEST FAIL");
    end else begin
        // let the bus settle a few cycles after halt
        cycles = 0;
        while (cycles < 8) begin
            @(posedge clk);
            cycles++;
        end
        if (exp_addr.size() != 0) begin
            $display("%0d expected writes never happened", exp_addr.size());
            errors++;
        end
        check_value("byte lane word", 24'h003455, {8'h00, mem[16'h0100]});
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
            dmp_addr <= 3'(i);
            @(negedge clk);
            check_value($sformatf("dump r%0d", i), {8'h00, model[i]}, {8'h00, dmp_dout});
        end
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
    end
    $finish;
end

endmodule

// File: tb.f
+incdir+include
design/cpu_isa_pkg.sv
design/cpu_core_pkg.sv
design/cpu_ctrl.sv
design/cpu_regs.sv
design/cpu_alu.sv
design/cpu_pc.sv
design/cpu_busctl.sv
design/cpu_top.sv
testbench/cpu_assert.sv
testbench/tb_cpu.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_cpu -o sim_tb_cpu

# a failed assertion stops the run, which the log search below catches
./obj_dir/sim_tb_cpu > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAIL" sim.log || ! grep -q "TEST PASS" sim.log; then
    exit 1
fi
exit 0
